// ==== tb.f ====
+incdir+include
logic/cfgPkg.sv
logic/isaDecoder.sv
logic/wordCollector.sv
logic/cfgTop.sv
test/cfgMonitor.sv
test/tbCfgTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run with Verilator, pass only when the testbench reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbCfgTop -f tb.f -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }
simOut="$(./obj_dir/VtbCfgTop)"
echo "$simOut"
grep -qx "TEST OK" <<< "$simOut" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== test/tbCfgTop.sv ====
/*
 * Random instruction stream into cfgTop with random isaVld gaps and
 * random engine back-pressure. Checks live in cfgMonitor.
 * Unknown opcodes cover every value other than 2, 3 and 4.
 */
`include "cfgParams_params.svh"

module tbCfgTop;
    import cfgPkg::*;

    localparam int NumInstr  = 60;
    // Watchdog budget in clock cycles
    localparam int MaxCycles = NumInstr * 50 + 200;

    logic     clk;
    logic     rst_n;
    isaWord_t isaWord;
    logic     isaVld;
    logic     isaRdy;
    itfCfg_t  itfCfg;
    logic     itfCfgVld;
    logic     itfCfgRdy;
    knnCfg_t  knnCfg;
    logic     knnCfgVld;
    logic     knnCfgRdy;
    syaCfg_t  syaCfg;
    logic     syaCfgVld;
    logic     syaCfgRdy;
    int       valueErrs;
    int       protocolErrs;
    int       pending;

    cfgTop UUT (.*);

    cfgMonitor uMonitor (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Stimulus
    // ==================================================
    // Holds the word until the edge that transfers it
    task automatic sendWord(input isaWord_t w);
        int gap;
        gap = $urandom_range(0, 3);
        if (gap > 0) begin
            isaVld  <= 1'b0;
            isaWord <= {$urandom, $urandom, $urandom, $urandom};
            repeat (gap) @(posedge clk);
        end
        isaVld  <= 1'b1;
        isaWord <= w;
        @(negedge clk);
        while (!isaRdy) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic sendInstr(input opcode_t op, input int nWords);
        isaWord_t w;
        for (int i = 0; i < nWords; i++) begin
            w = {$urandom, $urandom, $urandom, $urandom};
            if (i == 0) begin
                w[`CFG_OPCODE_W-1:0] = op;
            end
            sendWord(w);
        end
    endtask

    // Random opcode outside 2 to 4
    function automatic opcode_t unknownOpcode();
        opcode_t op;
        op = opcode_t'($urandom_range(0, 252));
        return (op < 8'd2) ? op : op + 8'd3;
    endfunction

    // Engines accept about one cycle in three
    task automatic driveReady();
        forever begin
            @(posedge clk);
            itfCfgRdy <= ($urandom_range(0, 2) == 0);
            knnCfgRdy <= ($urandom_range(0, 2) == 0);
            syaCfgRdy <= ($urandom_range(0, 2) == 0);
        end
    endtask

    initial begin
        int pick;
        rst_n     = 1'b0;
        isaVld    = 1'b0;
        isaWord   = '0;
        itfCfgRdy = 1'b0;
        knnCfgRdy = 1'b0;
        syaCfgRdy = 1'b0;
        void'($urandom(60));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        fork
            driveReady();
        join_none
        // Bus stays idle for a while after reset
        repeat (5) @(posedge clk);
        for (int n = 0; n < NumInstr; n++) begin
            pick = $urandom_range(0, 4);
            case (pick)
                0:       sendInstr(OpItf, `CFG_ITF_WORDS);
                1:       sendInstr(OpKnn, `CFG_KNN_WORDS);
                2, 3:    sendInstr(OpSya, `CFG_SYA_WORDS);
                default: sendInstr(unknownOpcode(), 1);
            endcase
        end
        isaVld <= 1'b0;
        // Drain configurations still waiting for their engine
        @(negedge clk);
        while (pending != 0) @(negedge clk);
        repeat (10) @(posedge clk);
        $display("Error counts: value %0d, protocol %0d", valueErrs, protocolErrs);
        if (valueErrs == 0 && protocolErrs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ==================================================
    // Watchdog
    // ==================================================
    initial begin
        repeat (MaxCycles) @(posedge clk);
        $display("Timeout: run did not complete within %0d cycles", MaxCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== test/cfgMonitor.sv ====
/*
 * Reference model and checks for cfgTop. Expected configurations are
 * rebuilt from accepted words, one queue per engine. Any opcode other
 * than 2, 3 or 4 is taken to consume exactly one word.
 */
`include "cfgParams_params.svh"

module cfgMonitor (
    input  logic             clk,
    input  logic             rst_n,
    input  cfgPkg::isaWord_t isaWord,
    input  logic             isaVld,
    input  logic             isaRdy,
    input  cfgPkg::itfCfg_t  itfCfg,
    input  logic             itfCfgVld,
    input  logic             itfCfgRdy,
    input  cfgPkg::knnCfg_t  knnCfg,
    input  logic             knnCfgVld,
    input  logic             knnCfgRdy,
    input  cfgPkg::syaCfg_t  syaCfg,
    input  logic             syaCfgVld,
    input  logic             syaCfgRdy,
    output int               valueErrs,
    output int               protocolErrs,
    output int               pending
);
    import cfgPkg::*;

    localparam int CfgW = $bits(syaCfg_t);
    // Engine code of an opcode that selects nothing
    localparam logic [1:0] NoEng = 2'd3;

    typedef logic [CfgW-1:0] cfgVec_t;

    logic [`CFG_NUM_ENG-1:0]               vld;
    logic [`CFG_NUM_ENG-1:0]               rdy;
    logic [`CFG_NUM_ENG-1:0]               have;
    logic [`CFG_NUM_ENG-1:0]               lastAcc;
    cfgVec_t                               act [`CFG_NUM_ENG];
    cfgVec_t                               expFront [`CFG_NUM_ENG];
    cfgVec_t                               expQ [`CFG_NUM_ENG][$];
    logic [`CFG_SYA_WORDS*`CFG_WORD_W-1:0] words;
    logic [1:0]                            curEng;
    logic [1:0]                            busyEng;
    logic                                  busy;
    logic                                  seenVld;
    int                                    wordIdx;
    int                                    curWords;
    int                                    valErrCnt = 0;
    int                                    protoErrCnt = 0;

    assign vld[`CFG_ENG_ITF] = itfCfgVld;
    assign vld[`CFG_ENG_KNN] = knnCfgVld;
    assign vld[`CFG_ENG_SYA] = syaCfgVld;
    assign rdy[`CFG_ENG_ITF] = itfCfgRdy;
    assign rdy[`CFG_ENG_KNN] = knnCfgRdy;
    assign rdy[`CFG_ENG_SYA] = syaCfgRdy;
    assign act[`CFG_ENG_ITF] = CfgW'(itfCfg);
    assign act[`CFG_ENG_KNN] = CfgW'(knnCfg);
    assign act[`CFG_ENG_SYA] = CfgW'(syaCfg);

    assign valueErrs    = valErrCnt;
    assign protocolErrs = protoErrCnt;
    assign pending      = $countones(have);

    // ==================================================
    // Reference model
    // ==================================================
    function automatic logic [1:0] engOf(input opcode_t op);
        case (op)
            8'd4:    return 2'(`CFG_ENG_ITF);
            8'd2:    return 2'(`CFG_ENG_KNN);
            8'd3:    return 2'(`CFG_ENG_SYA);
            default: return NoEng;
        endcase
    endfunction

    // First word lowest and the struct starts right above the opcode byte
    function automatic cfgVec_t expectedCfg(input logic [1:0] eng,
                                            input logic [`CFG_SYA_WORDS*`CFG_WORD_W-1:0] bits);
        int w;
        w = (eng == `CFG_ENG_ITF) ? $bits(itfCfg_t) :
            (eng == `CFG_ENG_KNN) ? $bits(knnCfg_t) : CfgW;
        return CfgW'(bits >> `CFG_OPCODE_W) & ({CfgW{1'b1}} >> (CfgW - w));
    endfunction

    task automatic protoFail(input string msg);
        protoErrCnt++;
        $display("At %0t: %s", $time, msg);
    endtask

    task automatic valueFail(input string msg);
        valErrCnt++;
        $display("CHECK FAILED t=%0t %s", $time, msg);
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < `CFG_NUM_ENG; e++) begin
                expQ[e].delete();
            end
            wordIdx  = 0;
            curWords = 1;
            curEng   = NoEng;
            words    = '0;
            busy    <= 1'b0;
            busyEng <= '0;
            seenVld <= 1'b0;
            lastAcc <= '0;
            have    <= '0;
        end else begin
            lastAcc <= '0;
            if (isaVld) begin
                seenVld <= 1'b1;
            end
            // Delivered configuration retires the oldest expectation
            for (int e = 0; e < `CFG_NUM_ENG; e++) begin
                if (vld[e] && rdy[e] && expQ[e].size() > 0) begin
                    void'(expQ[e].pop_front());
                end
            end
            if (busy && vld[busyEng] && rdy[busyEng]) begin
                busy <= 1'b0;
            end
            if (isaVld && isaRdy) begin
                if (wordIdx == 0) begin
                    curEng   = engOf(isaWord[`CFG_OPCODE_W-1:0]);
                    curWords = (curEng == `CFG_ENG_SYA) ? `CFG_SYA_WORDS :
                               (curEng == `CFG_ENG_ITF) ? `CFG_ITF_WORDS :
                               (curEng == `CFG_ENG_KNN) ? `CFG_KNN_WORDS : 1;
                    words[`CFG_WORD_W-1:0] = isaWord;
                end else begin
                    words[2*`CFG_WORD_W-1:`CFG_WORD_W] = isaWord;
                end
                wordIdx = wordIdx + 1;
                if (wordIdx == curWords) begin
                    wordIdx = 0;
                    if (curEng != NoEng) begin
                        expQ[curEng].push_back(expectedCfg(curEng, words));
                        lastAcc[curEng] <= 1'b1;
                        busy            <= 1'b1;
                        busyEng         <= curEng;
                    end
                end
            end
            for (int e = 0; e < `CFG_NUM_ENG; e++) begin
                have[e]     <= expQ[e].size() > 0;
                expFront[e] <= (expQ[e].size() > 0) ? expQ[e][0] : '0;
            end
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    quietAfterReset: assert property (@(posedge clk) disable iff (!rst_n)
        !seenVld |-> !isaRdy && vld == '0)
        else protoFail("handshake active before the first instruction word");

    // Only one instruction in flight
    noFetchWhileBusy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !isaRdy)
        else protoFail("isaRdy high while the current configuration waits");

    for (genvar e = 0; e < `CFG_NUM_ENG; e++) begin : gEng
        localparam string Name = (e == `CFG_ENG_ITF) ? "itfCfg" :
                                 (e == `CFG_ENG_KNN) ? "knnCfg" : "syaCfg";

        vldAfterLast: assert property (@(posedge clk) disable iff (!rst_n)
            lastAcc[e] |-> vld[e])
            else protoFail({Name, "Vld did not rise after the last word"});

        noSpurious: assert property (@(posedge clk) disable iff (!rst_n)
            vld[e] && rdy[e] |-> have[e])
            else protoFail({Name, " delivered with no instruction behind it"});

        holdStable: assert property (@(posedge clk) disable iff (!rst_n)
            vld[e] && !rdy[e] |=> vld[e] && $stable(act[e]))
            else protoFail({Name, " dropped or changed before its handshake"});

        rightValue: assert property (@(posedge clk) disable iff (!rst_n)
            vld[e] && rdy[e] && have[e] |-> act[e] == expFront[e])
            else valueFail($sformatf("%s expected=%h actual=%h", Name,
                                     $sampled(expFront[e]), $sampled(act[e])));
    end

endmodule

// ==== logic/cfgTop.sv ====
/*
 * Configuration control unit top. Opcodes 2, 3 and 4 go to the kNN
 * unit, systolic array and off-chip interface, others are dropped.
 * Struct fields start right above the opcode byte of the first word.
 */
`include "cfgParams_params.svh"

module cfgTop (
    input  logic             clk,
    input  logic             rst_n,

    input  cfgPkg::isaWord_t isaWord,
    input  logic             isaVld,
    output logic             isaRdy,

    output cfgPkg::itfCfg_t  itfCfg,
    output logic             itfCfgVld,
    input  logic             itfCfgRdy,

    output cfgPkg::knnCfg_t  knnCfg,
    output logic             knnCfgVld,
    input  logic             knnCfgRdy,

    output cfgPkg::syaCfg_t  syaCfg,
    output logic             syaCfgVld,
    input  logic             syaCfgRdy
);
    import cfgPkg::*;

    logic [`CFG_NUM_ENG-1:0]                wordVld;
    logic [`CFG_NUM_ENG-1:0]                collectorRdy;
    logic [`CFG_NUM_ENG-1:0]                cfgDone;

    logic [`CFG_ITF_WORDS*`CFG_WORD_W-1:0]  itfBits;
    logic [`CFG_KNN_WORDS*`CFG_WORD_W-1:0]  knnBits;
    logic [`CFG_SYA_WORDS*`CFG_WORD_W-1:0]  syaBits;

    // ==================================================
    // Fetch and decode
    // ==================================================
    isaDecoder uDecoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .isaWord      (isaWord),
        .isaVld       (isaVld),
        .isaRdy       (isaRdy),
        .wordVld      (wordVld),
        .collectorRdy (collectorRdy),
        .cfgDone      (cfgDone)
    );

    // ==================================================
    // Per-engine collectors
    // ==================================================
    // All collectors share the word bus, only wordVld is steered
    wordCollector #(.NumWords(`CFG_ITF_WORDS)) uItfCollector (
        .clk     (clk),
        .rst_n   (rst_n),
        .word    (isaWord),
        .wordVld (wordVld[`CFG_ENG_ITF]),
        .inRdy   (collectorRdy[`CFG_ENG_ITF]),
        .cfgBits (itfBits),
        .cfgVld  (itfCfgVld),
        .cfgRdy  (itfCfgRdy),
        .cfgDone (cfgDone[`CFG_ENG_ITF])
    );

    wordCollector #(.NumWords(`CFG_KNN_WORDS)) uKnnCollector (
        .clk     (clk),
        .rst_n   (rst_n),
        .word    (isaWord),
        .wordVld (wordVld[`CFG_ENG_KNN]),
        .inRdy   (collectorRdy[`CFG_ENG_KNN]),
        .cfgBits (knnBits),
        .cfgVld  (knnCfgVld),
        .cfgRdy  (knnCfgRdy),
        .cfgDone (cfgDone[`CFG_ENG_KNN])
    );

    // Two words, the second one holds the upper fields
    wordCollector #(.NumWords(`CFG_SYA_WORDS)) uSyaCollector (
        .clk     (clk),
        .rst_n   (rst_n),
        .word    (isaWord),
        .wordVld (wordVld[`CFG_ENG_SYA]),
        .inRdy   (collectorRdy[`CFG_ENG_SYA]),
        .cfgBits (syaBits),
        .cfgVld  (syaCfgVld),
        .cfgRdy  (syaCfgRdy),
        .cfgDone (cfgDone[`CFG_ENG_SYA])
    );

    // ==================================================
    // Unpacking
    // ==================================================
    // Skip the opcode byte, bits above each struct are ignored
    assign itfCfg = itfCfg_t'(itfBits[`CFG_OPCODE_W +: $bits(itfCfg_t)]);
    assign knnCfg = knnCfg_t'(knnBits[`CFG_OPCODE_W +: $bits(knnCfg_t)]);
    assign syaCfg = syaCfg_t'(syaBits[`CFG_OPCODE_W +: $bits(syaCfg_t)]);

endmodule

// ==== logic/wordCollector.sv ====
/*
 * Serial-to-parallel collector for one engine. First word lands in
 * the lowest slot. Output stays valid and stable until cfgRdy, and no
 * word is taken meanwhile. cfgDone is combinational on the handshake.
 */
`include "cfgParams_params.svh"

module wordCollector #(
    parameter int NumWords = 1
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  cfgPkg::isaWord_t                 word,
    input  logic                             wordVld,
    output logic                             inRdy,
    output logic [NumWords*`CFG_WORD_W-1:0]  cfgBits,
    output logic                             cfgVld,
    input  logic                             cfgRdy,
    output logic                             cfgDone
);
    import cfgPkg::*;

    // Counter also covers the full state, hence one extra code
    localparam int CntW = $clog2(NumWords + 1);
    localparam logic [CntW-1:0] CntFull = CntW'(NumWords);

    logic [CntW-1:0]           wordCnt;
    isaWord_t [NumWords-1:0]   slots;
    logic                      accept;

    // ==================================================
    // Handshakes
    // ==================================================
    assign cfgVld  = (wordCnt == CntFull);
    assign inRdy   = !cfgVld;
    assign accept  = wordVld && inRdy;
    assign cfgDone = cfgVld && cfgRdy;

    // ==================================================
    // Word counter
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wordCnt <= '0;
        end else if (cfgDone) begin
            wordCnt <= '0;
        end else if (accept) begin
            wordCnt <= wordCnt + 1'b1;
        end
    end

    // ==================================================
    // Slot storage
    // ==================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            slots[wordCnt] <= word;
        end
    end

    assign cfgBits = slots;

    // ==================================================
    // Assertions
    // ==================================================
    // Engine sees a stable configuration under back-pressure
    holdUntilRdy: assert property (@(posedge clk) disable iff (!rst_n)
        cfgVld && !cfgRdy |=> cfgVld && $stable(cfgBits))
        else $error("wordCollector: output changed before handshake");

    // Decoder must not push words into a full collector
    noWordWhileFull: assert property (@(posedge clk) disable iff (!rst_n)
        !(wordVld && cfgVld))
        else $error("wordCollector: word offered while cfgVld high");

endmodule

// ==== logic/isaDecoder.sv ====
/*
 * Instruction fetch FSM. The first word is only peeked in Idle and
 * consumed in Dec by the collector picked from its opcode.
 * Unknown opcodes drop exactly one word. One instruction in flight.
 */
`include "cfgParams_params.svh"

module isaDecoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cfgPkg::isaWord_t        isaWord,
    input  logic                    isaVld,
    output logic                    isaRdy,
    output logic [`CFG_NUM_ENG-1:0] wordVld,
    input  logic [`CFG_NUM_ENG-1:0] collectorRdy,
    input  logic [`CFG_NUM_ENG-1:0] cfgDone
);
    import cfgPkg::*;

    decState_e               state;
    decState_e               nextState;
    opcode_t                 opcode;
    logic [`CFG_NUM_ENG-1:0] engSel;
    logic                    knownOp;
    logic                    engDone;

    // ==================================================
    // Opcode decode
    // ==================================================
    always_comb begin
        engSel = '0;
        case (opcode)
            OpItf: engSel[`CFG_ENG_ITF] = 1'b1;
            OpKnn: engSel[`CFG_ENG_KNN] = 1'b1;
            OpSya: engSel[`CFG_ENG_SYA] = 1'b1;
            default: engSel = '0;
        endcase
    end

    assign knownOp = |engSel;
    // Selected engine took its configuration
    assign engDone = |(engSel & cfgDone);

    // ==================================================
    // Handshake steering
    // ==================================================
    // Unknown opcode is swallowed by accepting one word
    assign isaRdy = (state == Dec) && (knownOp ? |(engSel & collectorRdy) : 1'b1);

    // Valid reaches only the selected collector, and only while it can take a word
    assign wordVld = (state == Dec) ? (engSel & collectorRdy & {`CFG_NUM_ENG{isaVld}})
                                    : '0;

    // ==================================================
    // FSM
    // ==================================================
    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (isaVld) begin
                    nextState = Dec;
                end
            end
            Dec: begin
                if (!knownOp && isaVld) begin
                    nextState = Idle;
                end else if (engDone) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= Idle;
            opcode <= '0;
        end else begin
            state <= nextState;
            // Peek the opcode without consuming the word
            if (state == Idle && isaVld) begin
                opcode <= isaWord[`CFG_OPCODE_W-1:0];
            end
        end
    end

    // ==================================================
    // Assertions
    // ==================================================
    // Opcode holds for the whole instruction
    opcodeStable: assert property (@(posedge clk) disable iff (!rst_n)
        (state == Dec) |=> (state == Idle) || $stable(opcode))
        else $error("isaDecoder: opcode changed during Dec");

    // First word is never consumed before decode
    noRdyInIdle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == Idle) |-> !isaRdy)
        else $error("isaDecoder: isaRdy high in Idle");

endmodule

// ==== logic/cfgPkg.sv ====
/*
 * Types for the configuration control unit.
 * Packed structs list members MSB first, so the field that sits
 * just above the opcode is the last one in each declaration.
 */
`include "cfgParams_params.svh"

package cfgPkg;

    // ==================================================
    // Vector types
    // ==================================================
    typedef logic [`CFG_WORD_W-1:0]   isaWord_t;
    typedef logic [`CFG_OPCODE_W-1:0] opcode_t;

    // Point index or point count
    typedef logic [15:0] idx_t;
    // Global buffer address
    typedef logic [15:0] addr_t;
    typedef logic [31:0] dramAddr_t;
    typedef logic [11:0] chn_t;
    // Requantization scale
    typedef logic [19:0] scale_t;
    // Activation shift or zero point
    typedef logic [7:0]  act_t;
    typedef logic [5:0]  knnK_t;

    // ==================================================
    // Enums
    // ==================================================
    typedef enum opcode_t {
        OpKnn = 8'd2,
        OpSya = 8'd3,
        OpItf = 8'd4
    } opcode_e;

    typedef enum logic {
        Idle,
        Dec
    } decState_e;

    // ==================================================
    // Engine configurations
    // ==================================================
    // Off-chip transfer, inOut 0 loads on chip and 1 stores off chip
    typedef struct packed {
        idx_t      num;
        idx_t      glbBaseAddr;
        dramAddr_t dramBaseAddr;
        logic [7:0] inOut;
    } itfCfg_t;

    typedef struct packed {
        idx_t  mapWrAddr;
        idx_t  crdRdAddr;
        knnK_t k;
        idx_t  nip;
    } knnCfg_t;

    // Spans both words of the systolic array instruction
    typedef struct packed {
        addr_t      ofmWrBaseAddr;
        addr_t      wgtRdBaseAddr;
        addr_t      actRdBaseAddr;
        logic       loopOrder;
        idx_t       numTilIfm;
        idx_t       numTilFlt;
        idx_t       numGrpPerTile;
        scale_t     scale;
        chn_t       chn;
        logic       ofmPhaseShift;
        logic [1:0] mode;
        act_t       zp;
        act_t       shift;
    } syaCfg_t;

endpackage

// ==== include/cfgParams_params.svh ====
/*
 * Build-time sizes of the configuration control unit.
 * Word counts must cover each engine struct plus the opcode byte,
 * and engine indices must stay below CFG_NUM_ENG.
 */
`ifndef CFG_PARAMS_SVH
`define CFG_PARAMS_SVH

// ==================================================
// Instruction word
// ==================================================
// Width of one word read from the global buffer
`define CFG_WORD_W      128
// Opcode field at the bottom of the first word
`define CFG_OPCODE_W    8

// ==================================================
// Words per instruction
// ==================================================
`define CFG_ITF_WORDS   1
`define CFG_KNN_WORDS   1
`define CFG_SYA_WORDS   2

// ==================================================
// Engine slots
// ==================================================
// Bit positions in the per-engine valid/ready vectors
`define CFG_NUM_ENG     3
`define CFG_ENG_ITF     0
`define CFG_ENG_KNN     1
`define CFG_ENG_SYA     2

`endif
